/* design/burst_sink.sv */
/*
  consumer of one node: registers each delivered word to the outputs
  burst_done pulses with recv_last, carrying the sender of the burst
*/
module burst_sink (
    input  logic                                clock,
    input  logic                                reset,
    input  mesh_pkg::flit_t                     flit_in,
    output logic                                recv_valid,
    output logic                                recv_last,
    output mesh_pkg::node_id_t                  recv_src,
    output logic [mesh_pkg::data_width-1:0]     recv_data,
    output logic                                burst_done,
    output mesh_pkg::node_id_t                  done_src
);
    import mesh_pkg::*;

    flit_t word;

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            word <= idle_flit;
        end
        else
        begin
            word <= flit_in;
        end
    end

    assign recv_valid = word.valid;
    assign recv_last  = word.valid && word.last;
    assign recv_src   = word.src;
    assign recv_data  = word.data;

    // last word seen, the allocator may release the path
    assign burst_done = word.valid && word.last;
    assign done_src   = word.src;

endmodule

/* design/burst_source.sv */
/*
  producer of one node: takes a burst request, asks for a path,
  then streams len words first, first+1, ... wrapping at 8 bits
  req must stay stable while req_valid is high; len must be nonzero
  flit_out is driven from state, words start the cycle after path_grant
*/
module burst_source #(
    parameter mesh_pkg::node_id_t node = '0
) (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 req_valid,
    output logic                 req_ready,
    input  mesh_pkg::burst_req_t req,
    output logic                 path_req,
    output mesh_pkg::node_id_t   path_dst,
    input  logic                 path_grant,
    output mesh_pkg::flit_t      flit_out
);
    import mesh_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_wait,
        st_send
    } state_t;

    state_t                state;
    node_id_t              dst;
    burst_len_t            remaining;
    logic [data_width-1:0] data;

    // idle -> wait for grant -> send len words -> idle
    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            state <= st_idle;
        end
        else
        begin
            case (state)
                st_idle:
                begin
                    if (req_valid)
                    begin
                        state <= st_wait;
                    end
                end
                st_wait:
                begin
                    if (path_grant)
                    begin
                        state <= st_send;
                    end
                end
                default:
                begin
                    // last word is on flit_out this cycle
                    if (remaining == burst_len_t'(1))
                    begin
                        state <= st_idle;
                    end
                end
            endcase
        end
    end

    // request fields, word counter and running data value
    always_ff @(posedge clock)
    begin
        if (state == st_idle && req_valid)
        begin
            dst       <= req.dst;
            remaining <= req.len;
            data      <= req.first;
        end
        else if (state == st_send)
        begin
            remaining <= remaining - burst_len_t'(1);
            data      <= data + 1'b1;
        end
    end

    assign req_ready = (state == st_idle);
    assign path_req  = (state == st_wait);
    assign path_dst  = dst;

    always_comb
    begin
        flit_out.valid = (state == st_send);
        flit_out.last  = (state == st_send) && (remaining == burst_len_t'(1));
        flit_out.src   = node;
        flit_out.data  = data;
    end

endmodule

/* design/mesh_pkg.sv */
/*
  shared types for the 2x2 circuit-switched mesh
  nodes 0,1 bottom row and 2,3 top row; horizontal pairs 0-1, 2-3
  bursts hold 1 to 255 words, a length of zero is not supported
  path_table knows no self transfer, src must differ from dst
*/
package mesh_pkg;

    localparam int node_count = 4;
    localparam int data_width = 8;

    typedef logic [1:0] node_id_t;
    typedef logic [7:0] burst_len_t;

    // one word on a link
    typedef struct packed {
        logic                  valid;
        logic                  last;
        node_id_t              src;
        logic [data_width-1:0] data;
    } flit_t;

    localparam flit_t idle_flit = '0;

    // burst request from outside, word 0 carries first
    typedef struct packed {
        node_id_t              dst;
        burst_len_t            len;
        logic [data_width-1:0] first;
    } burst_req_t;

    // which router input drives an output
    typedef enum logic [1:0] {
        sel_none  = 2'd0,
        sel_local = 2'd1,
        sel_horiz = 2'd2,
        sel_vert  = 2'd3
    } port_sel_t;

    // select word of one router, one field per output
    typedef struct packed {
        port_sel_t horiz;
        port_sel_t vert;
        port_sel_t loc;
    } route_sel_t;

    // bits 0..3 horizontal links by sender, 4..7 vertical links 0-2, 2-0, 1-3, 3-1
    typedef logic [7:0] link_mask_t;

    typedef struct packed {
        link_mask_t       links;
        route_sel_t [3:0] routes;
    } path_t;

    function automatic port_sel_t dir_of(node_id_t a, node_id_t b);
        return ((a ^ b) == 2'd1) ? sel_horiz : sel_vert;
    endfunction

    function automatic int link_idx(node_id_t a, node_id_t b);
        if ((a ^ b) == 2'd1)
        begin
            return int'(a);
        end
        return 4 + int'({a[0], a[1]});
    endfunction

    // choice 0: direct hop, or via horizontal corner for diagonals
    // choice 1: three-hop detour, or via vertical corner for diagonals
    function automatic path_t path_table(node_id_t src, node_id_t dst, logic choice);
        node_id_t  hops [4];
        node_id_t  side;
        int        hop_n;
        port_sel_t in_sel;
        path_t     p;
        p      = '0;
        side   = ~(src ^ dst);
        in_sel = sel_local;
        hops[0] = src;
        hops[3] = dst;
        if ((src ^ dst) == 2'd3)
        begin
            hops[1] = choice ? (src ^ 2'd2) : (src ^ 2'd1);
            hops[2] = dst;
            hop_n   = 2;
        end
        else if (!choice)
        begin
            hops[1] = dst;
            hops[2] = dst;
            hop_n   = 1;
        end
        else
        begin
            // step off onto the other axis, cross, come back
            hops[1] = src ^ side;
            hops[2] = dst ^ side;
            hop_n   = 3;
        end
        for (int i = 0; i < 3; i++)
        begin
            if (i < hop_n)
            begin
                if (dir_of(hops[i], hops[i+1]) == sel_horiz)
                begin
                    p.routes[hops[i]].horiz = in_sel;
                end
                else
                begin
                    p.routes[hops[i]].vert = in_sel;
                end
                p.links[link_idx(hops[i], hops[i+1])] = 1'b1;
                // next router sees the word on the side it came from
                in_sel = dir_of(hops[i], hops[i+1]);
            end
        end
        p.routes[dst].loc = in_sel;
        return p;
    endfunction

endpackage

/* design/mesh_router.sv */
/*
  router of one node: three registered outputs, each loading the
  input named by its select field, or an idle word when none
  one cycle per hop; no flow control, links are reserved ahead
*/
module mesh_router (
    input  logic                 clock,
    input  logic                 reset,
    input  mesh_pkg::route_sel_t sel,
    input  mesh_pkg::flit_t      in_local,
    input  mesh_pkg::flit_t      in_horiz,
    input  mesh_pkg::flit_t      in_vert,
    output mesh_pkg::flit_t      out_local,
    output mesh_pkg::flit_t      out_horiz,
    output mesh_pkg::flit_t      out_vert
);
    import mesh_pkg::*;

    // crossbar leg of one output
    function automatic flit_t pick(port_sel_t s, flit_t loc, flit_t hor, flit_t ver);
        case (s)
            sel_local: return loc;
            sel_horiz: return hor;
            sel_vert:  return ver;
            default:   return idle_flit;
        endcase
    endfunction

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            out_local <= idle_flit;
            out_horiz <= idle_flit;
            out_vert  <= idle_flit;
        end
        else
        begin
            // local output feeds the sink, the others the neighbor links
            out_local <= pick(sel.loc, in_local, in_horiz, in_vert);
            out_horiz <= pick(sel.horiz, in_local, in_horiz, in_vert);
            out_vert  <= pick(sel.vert, in_local, in_horiz, in_vert);
        end
    end

endmodule

/* design/mesh_top.sv */
/*
  2x2 mesh: 2 - 3 on top, 0 - 1 at the bottom
  each node has a source, a router and a sink; one allocator reserves paths
  the mesh has no edge ports, all traffic stays between the four nodes
*/
module mesh_top (
    input  logic                                    clock,
    input  logic                                    reset,
    input  logic                                    block_all_paths,
    input  logic [3:0]                              req_valid,
    input  mesh_pkg::burst_req_t [3:0]              req,
    output logic [3:0]                              req_ready,
    output logic [3:0]                              recv_valid,
    output logic [3:0]                              recv_last,
    output mesh_pkg::node_id_t [3:0]                recv_src,
    output logic [3:0][mesh_pkg::data_width-1:0]    recv_data
);
    import mesh_pkg::*;

    logic [3:0]       path_req;
    node_id_t [3:0]   path_dst;
    logic [3:0]       path_grant;
    logic [3:0]       burst_done;
    node_id_t [3:0]   done_src;
    route_sel_t [3:0] route_sel;

    // router outputs by sender; a neighbor reads its partner's entry
    flit_t src_flit   [node_count];
    flit_t horiz_link [node_count];
    flit_t vert_link  [node_count];
    flit_t sink_flit  [node_count];

    path_allocator u_alloc (
        .clock           (clock),
        .reset           (reset),
        .block_all_paths (block_all_paths),
        .path_req        (path_req),
        .path_dst        (path_dst),
        .path_grant      (path_grant),
        .burst_done      (burst_done),
        .done_src        (done_src),
        .route_sel       (route_sel)
    );

    for (genvar i = 0; i < node_count; i++)
    begin : g_node
        burst_source #(
            .node (node_id_t'(i))
        ) u_source (
            .clock      (clock),
            .reset      (reset),
            .req_valid  (req_valid[i]),
            .req_ready  (req_ready[i]),
            .req        (req[i]),
            .path_req   (path_req[i]),
            .path_dst   (path_dst[i]),
            .path_grant (path_grant[i]),
            .flit_out   (src_flit[i])
        );

        // horizontal partner is i^1, vertical partner is i^2
        mesh_router u_router (
            .clock     (clock),
            .reset     (reset),
            .sel       (route_sel[i]),
            .in_local  (src_flit[i]),
            .in_horiz  (horiz_link[i ^ 1]),
            .in_vert   (vert_link[i ^ 2]),
            .out_local (sink_flit[i]),
            .out_horiz (horiz_link[i]),
            .out_vert  (vert_link[i])
        );

        burst_sink u_sink (
            .clock      (clock),
            .reset      (reset),
            .flit_in    (sink_flit[i]),
            .recv_valid (recv_valid[i]),
            .recv_last  (recv_last[i]),
            .recv_src   (recv_src[i]),
            .recv_data  (recv_data[i]),
            .burst_done (burst_done[i]),
            .done_src   (done_src[i])
        );
    end

endmodule

/* design/path_allocator.sv */
/*
  central path allocator, one grant per cycle at most
  lowest node index first, choice 0 before choice 1
  a source holds one path until its sink reports the last word
  block_all_paths stops new grants only, frees still happen
*/
module path_allocator (
    input  logic                           clock,
    input  logic                           reset,
    input  logic                           block_all_paths,
    input  logic [3:0]                     path_req,
    input  mesh_pkg::node_id_t [3:0]       path_dst,
    output logic [3:0]                     path_grant,
    input  logic [3:0]                     burst_done,
    input  mesh_pkg::node_id_t [3:0]       done_src,
    output mesh_pkg::route_sel_t [3:0]     route_sel
);
    import mesh_pkg::*;

    link_mask_t       link_busy;
    logic [3:0][2:0]  out_busy;
    logic [3:0]       dst_busy;
    logic [3:0]       held_valid;
    path_t [3:0]      held;
    node_id_t [3:0]   held_dst;
    logic             grant_any;
    node_id_t         grant_idx;
    path_t            grant_path;
    link_mask_t       link_next;
    logic [3:0][2:0]  out_next;
    logic [3:0]       dst_next;
    logic [3:0]       held_next;
    route_sel_t [3:0] sel_next;

    // router outputs a path occupies, horiz/vert/local per router
    function automatic logic [3:0][2:0] out_use(path_t p);
        logic [3:0][2:0] u;
        for (int r = 0; r < node_count; r++)
        begin
            u[r] = {p.routes[r].horiz != sel_none, p.routes[r].vert != sel_none,
                    p.routes[r].loc != sel_none};
        end
        return u;
    endfunction

    // write or clear the fields a path uses
    function automatic route_sel_t merge_sel(route_sel_t cur, route_sel_t p, logic set);
        route_sel_t m;
        m = cur;
        if (p.horiz != sel_none) m.horiz = set ? p.horiz : sel_none;
        if (p.vert != sel_none) m.vert = set ? p.vert : sel_none;
        if (p.loc != sel_none) m.loc = set ? p.loc : sel_none;
        return m;
    endfunction

    // scan: first fitting request and choice wins
    always_comb
    begin
        path_t cand;
        grant_any  = 1'b0;
        grant_idx  = '0;
        grant_path = '0;
        for (int i = 0; i < node_count; i++)
        begin
            for (int c = 0; c < 2; c++)
            begin
                cand = path_table(node_id_t'(i), path_dst[i], c[0]);
                if (!grant_any && !block_all_paths && path_req[i] && !held_valid[i]
                    && !dst_busy[path_dst[i]] && ~|(cand.links & link_busy)
                    && ~|(out_use(cand) & out_busy))
                begin
                    grant_any  = 1'b1;
                    grant_idx  = node_id_t'(i);
                    grant_path = cand;
                end
            end
        end
    end

    // frees first, then the new grant; the two never overlap
    always_comb
    begin
        link_next = link_busy;
        out_next  = out_busy;
        dst_next  = dst_busy;
        held_next = held_valid;
        sel_next  = route_sel;
        for (int k = 0; k < node_count; k++)
        begin
            if (burst_done[k])
            begin
                link_next &= ~held[done_src[k]].links;
                out_next  &= ~out_use(held[done_src[k]]);
                dst_next[held_dst[done_src[k]]] = 1'b0;
                held_next[done_src[k]] = 1'b0;
                for (int r = 0; r < node_count; r++)
                begin
                    sel_next[r] = merge_sel(sel_next[r], held[done_src[k]].routes[r], 1'b0);
                end
            end
        end
        if (grant_any)
        begin
            link_next |= grant_path.links;
            out_next  |= out_use(grant_path);
            dst_next[path_dst[grant_idx]] = 1'b1;
            held_next[grant_idx] = 1'b1;
            for (int r = 0; r < node_count; r++)
            begin
                sel_next[r] = merge_sel(sel_next[r], grant_path.routes[r], 1'b1);
            end
        end
    end

    always_ff @(posedge clock)
    begin
        if (reset)
        begin
            link_busy  <= '0;
            out_busy   <= '0;
            dst_busy   <= '0;
            held_valid <= '0;
            route_sel  <= '0;
            path_grant <= '0;
        end
        else
        begin
            link_busy  <= link_next;
            out_busy   <= out_next;
            dst_busy   <= dst_next;
            held_valid <= held_next;
            route_sel  <= sel_next;
            // one-cycle pulse to the granted source
            path_grant <= grant_any ? (4'b0001 << grant_idx) : 4'b0000;
        end
    end

    // remember the held path so a free can undo it
    always_ff @(posedge clock)
    begin
        if (grant_any)
        begin
            held[grant_idx]     <= grant_path;
            held_dst[grant_idx] <= path_dst[grant_idx];
        end
    end

endmodule

/* run.sh */
#!/bin/sh
# build and run the mesh testbench with Verilator, result read from sim.log
rm -f sim.log
verilator --binary --assert -Wno-fatal --top-module mesh_tb -f verilog.f \
    && ./obj_dir/Vmesh_tb | tee sim.log \
    || exit 1
grep -q "Test FAILED" sim.log && exit 1
grep -q "Test OK" sim.log || exit 1
exit 0

/* sim/mesh_tb.sv */
/*
  testbench for the 2x2 mesh, six tests run in a row
  concurrent assertions on the falling edge compare recv_* against
  a per-destination scoreboard built from the accepted requests
  inputs change 1 ns after the rising edge; watchdog bounds the run
*/
module mesh_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import mesh_pkg::*;

    logic                             clock;
    logic                             reset;
    logic                             block_all_paths;
    logic [3:0]                       req_valid;
    burst_req_t [3:0]                 req;
    logic [3:0]                       req_ready;
    logic [3:0]                       recv_valid;
    logic [3:0]                       recv_last;
    node_id_t [3:0]                   recv_src;
    logic [3:0][data_width-1:0]       recv_data;

    // accepted requests per source, oldest first
    burst_req_t                       pend_q [node_count][$];
    logic [3:0]                       head_valid;
    burst_req_t [3:0]                 head;
    // burst in progress per destination
    logic [3:0]                       active;
    node_id_t [3:0]                   exp_src;
    logic [3:0][data_width-1:0]       exp_data;
    burst_len_t [3:0]                 exp_left;
    int                               starts [node_count];
    // what the word on recv_* should look like
    logic [3:0]                       want_known;
    node_id_t [3:0]                   want_src;
    logic [3:0][data_width-1:0]       want_data;
    logic [3:0]                       want_last;
    logic [3:0]                       taken_q;

    int         words_req;
    int         words_rcvd;
    int         bursts_done;
    int         errors;
    int         err_mark;
    int         tests_run;
    int         tests_failed;
    string      test_name;
    logic       reset_check;
    logic       hold_check;
    logic       count_check;
    logic       order_check;
    int         order_base;
    node_id_t   order_src;

    int         seed;
    int         watch_cycles;
    logic       plan_ready;
    node_id_t   rnd_src   [12];
    node_id_t   rnd_dst   [12];
    int         rnd_len   [12];
    logic [7:0] rnd_first [12];

    mesh_top DUT (
        .clock           (clock),
        .reset           (reset),
        .block_all_paths (block_all_paths),
        .req_valid       (req_valid),
        .req             (req),
        .req_ready       (req_ready),
        .recv_valid      (recv_valid),
        .recv_last       (recv_last),
        .recv_src        (recv_src),
        .recv_data       (recv_data)
    );

    always #5 clock = ~clock;

    // scoreboard, sampled on the rising edge like a register
    always @(posedge clock)
    begin
        node_id_t   s;
        burst_req_t cur;
        if (reset)
        begin
            active  = '0;
            taken_q = '0;
            for (int k = 0; k < node_count; k++)
            begin
                pend_q[k].delete();
            end
        end
        else
        begin
            for (int d = 0; d < node_count; d++)
            begin
                if (recv_valid[d])
                begin
                    s = recv_src[d];
                    words_rcvd++;
                    // new burst only if its sender has a request for d
                    if (!active[d] && pend_q[s].size() > 0 && pend_q[s][0].dst == node_id_t'(d))
                    begin
                        cur         = pend_q[s].pop_front();
                        exp_src[d]  = s;
                        exp_data[d] = cur.first;
                        exp_left[d] = cur.len;
                        active[d]   = 1'b1;
                        starts[d]++;
                    end
                    if (active[d])
                    begin
                        exp_data[d] = exp_data[d] + 8'd1;
                        if (exp_left[d] == burst_len_t'(1))
                        begin
                            active[d] = 1'b0;
                            bursts_done++;
                        end
                        else
                        begin
                            exp_left[d] = exp_left[d] - burst_len_t'(1);
                        end
                    end
                end
            end
            // handshake on the request ports
            for (int k = 0; k < node_count; k++)
            begin
                taken_q[k] = req_valid[k] && req_ready[k];
                if (taken_q[k])
                begin
                    pend_q[k].push_back(req[k]);
                    words_req += int'(req[k].len);
                end
            end
        end
        for (int k = 0; k < node_count; k++)
        begin
            head_valid[k] = (pend_q[k].size() > 0);
            head[k]       = head_valid[k] ? pend_q[k][0] : '0;
        end
    end

    always_comb
    begin
        for (int d = 0; d < node_count; d++)
        begin
            if (active[d])
            begin
                want_known[d] = 1'b1;
                want_src[d]   = exp_src[d];
                want_data[d]  = exp_data[d];
                want_last[d]  = (exp_left[d] == burst_len_t'(1));
            end
            else
            begin
                // first word, taken from the sender's oldest request
                want_known[d] = head_valid[recv_src[d]]
                                && head[recv_src[d]].dst == node_id_t'(d);
                want_src[d]   = '0;
                want_data[d]  = head[recv_src[d]].first;
                want_last[d]  = (head[recv_src[d]].len == burst_len_t'(1));
            end
        end
    end

    for (genvar d = 0; d < node_count; d++)
    begin : g_check
        // words of a burst come back to back
        assert property (@(negedge clock) disable iff (reset) active[d] |-> recv_valid[d])
        else
        begin
            errors++;
            $display("error in test %s: burst to node %0d broke off before its last word",
                     test_name, d);
        end
        assert property (@(negedge clock) disable iff (reset) recv_valid[d] |-> want_known[d])
        else
        begin
            errors++;
            $display("error in test %s: node %0d got a word from node %0d with no request",
                     test_name, d, recv_src[d]);
        end
        // sender of a running burst must not change
        assert property (@(negedge clock) disable iff (reset)
                         (recv_valid[d] && active[d]) |-> recv_src[d] == want_src[d])
        else
        begin
            errors++;
            $display("** Error [%s] node %0d src expected %0d actual %0d",
                     test_name, d, want_src[d], recv_src[d]);
        end
        assert property (@(negedge clock) disable iff (reset)
                         (recv_valid[d] && want_known[d]) |-> recv_data[d] == want_data[d])
        else
        begin
            errors++;
            $display("** Error [%s] node %0d data expected %h actual %h",
                     test_name, d, want_data[d], recv_data[d]);
        end
        assert property (@(negedge clock) disable iff (reset)
                         (recv_valid[d] && want_known[d]) |-> recv_last[d] == want_last[d])
        else
        begin
            errors++;
            $display("** Error [%s] node %0d last expected %b actual %b",
                     test_name, d, want_last[d], recv_last[d]);
        end
        // source drops ready once it holds a request
        assert property (@(negedge clock) disable iff (reset) taken_q[d] |-> !req_ready[d])
        else
        begin
            errors++;
            $display("error in test %s: node %0d still ready after taking a request",
                     test_name, d);
        end
    end

    assert property (@(negedge clock) disable iff (reset)
                     reset_check |-> (req_ready == 4'hf && recv_valid == 4'h0))
    else
    begin
        errors++;
        $display("** Error [%s] ready/valid expected f/0 actual %h/%h",
                 test_name, req_ready, recv_valid);
    end

    assert property (@(negedge clock) disable iff (reset) hold_check |-> !recv_valid[2])
    else
    begin
        errors++;
        $display("error in test %s: node 2 received a word while paths were held",
                 test_name);
    end

    // lowest index wins when two bursts aim at node 1
    assert property (@(negedge clock) disable iff (reset)
                     (order_check && recv_valid[1] && starts[1] == order_base)
                     |-> recv_src[1] == order_src)
    else
    begin
        errors++;
        $display("** Error [%s] first sender at node 1 expected %0d actual %0d",
                 test_name, order_src, recv_src[1]);
    end

    assert property (@(negedge clock) disable iff (reset)
                     count_check |-> words_rcvd == words_req)
    else
    begin
        errors++;
        $display("** Error [%s] word count expected %0d actual %0d",
                 test_name, words_req, words_rcvd);
    end

    task automatic start_test(input string name);
        test_name = name;
        err_mark  = errors;
    endtask

    task automatic end_test();
        count_check = 1'b1;
        @(posedge clock);
        #1;
        count_check = 1'b0;
        tests_run++;
        if (errors != err_mark)
        begin
            tests_failed++;
        end
        $display("test %-8s %s", test_name, (errors == err_mark) ? "passed" : "failed");
    endtask

    task automatic post(input int s, input node_id_t d, input int len, input logic [7:0] first);
        req[s].dst   = d;
        req[s].len   = burst_len_t'(len);
        req[s].first = first;
        req_valid[s] = 1'b1;
    endtask

    // hold each posted request until its source takes it
    task automatic hand_over();
        logic [3:0] took;
        while (req_valid != 4'b0)
        begin
            @(posedge clock);
            took = req_valid & req_ready;
            #1;
            req_valid = req_valid & ~took;
        end
    endtask

    task automatic wait_done(input int target);
        while (bursts_done < target)
        begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic wait_ready(input int s);
        while (!req_ready[s])
        begin
            @(posedge clock);
            #1;
        end
    endtask

    task automatic make_random_list(output int words);
        words = 0;
        for (int k = 0; k < 12; k++)
        begin
            rnd_src[k]   = node_id_t'($unsigned($random(seed)) % 4);
            // any of the other three nodes
            rnd_dst[k]   = rnd_src[k] + node_id_t'(1 + $unsigned($random(seed)) % 3);
            rnd_len[k]   = 1 + $unsigned($random(seed)) % 16;
            rnd_first[k] = 8'($random(seed));
            words += rnd_len[k];
        end
    endtask

    initial
    begin
        int rnd_words;
        int base;
        clock = 1'b0;
        reset = 1'b1;
        block_all_paths = 1'b0;
        req_valid   = '0;
        req         = '0;
        reset_check = 1'b0;
        hold_check  = 1'b0;
        count_check = 1'b0;
        order_check = 1'b0;
        order_base  = 0;
        order_src   = '0;
        plan_ready  = 1'b0;
        seed        = 29;
        make_random_list(rnd_words);
        // 36 words in the fixed tests
        watch_cycles = 200 * 6 + 20 * (36 + rnd_words);
        plan_ready   = 1'b1;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;

        start_test("reset");
        reset_check = 1'b1;
        @(posedge clock);
        #1;
        reset_check = 1'b0;
        end_test();

        start_test("single");
        base = bursts_done;
        post(0, 2'd3, 6, 8'hf0);
        hand_over();
        wait_done(base + 1);
        wait_ready(0);
        end_test();

        start_test("disjoint");
        base = bursts_done;
        post(0, 2'd1, 5, 8'h10);
        post(2, 2'd3, 7, 8'h20);
        hand_over();
        wait_done(base + 2);
        end_test();

        start_test("same_dst");
        base        = bursts_done;
        order_src   = 2'd0;
        order_base  = starts[1];
        order_check = 1'b1;
        post(0, 2'd1, 4, 8'h40);
        post(2, 2'd1, 6, 8'h60);
        hand_over();
        wait_done(base + 2);
        order_check = 1'b0;
        end_test();

        start_test("hold");
        base = bursts_done;
        block_all_paths = 1'b1;
        post(1, 2'd2, 8, 8'h80);
        hand_over();
        hold_check = 1'b1;
        repeat (30)
        begin
            @(posedge clock);
            #1;
        end
        hold_check = 1'b0;
        block_all_paths = 1'b0;
        wait_done(base + 1);
        end_test();

        start_test("random");
        base = bursts_done;
        for (int k = 0; k < 12; k++)
        begin
            wait_ready(rnd_src[k]);
            post(rnd_src[k], rnd_dst[k], rnd_len[k], rnd_first[k]);
            hand_over();
        end
        wait_done(base + 12);
        end_test();

        $display("tests %0d, failed %0d, errors %0d, words %0d of %0d",
                 tests_run, tests_failed, errors, words_rcvd, words_req);
        if (errors == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

    // watchdog
    initial
    begin
        wait (plan_ready);
        repeat (watch_cycles) @(posedge clock);
        $display("run timed out after %0d cycles in test %s, a burst never finished",
                 watch_cycles, test_name);
        $display("Test FAILED");
        $finish;
    end

endmodule

/* verilog.f */
design/mesh_pkg.sv
design/burst_source.sv
design/mesh_router.sv
design/path_allocator.sv
design/burst_sink.sv
design/mesh_top.sv
sim/mesh_tb.sv
